// File: common/adder_tree_pkg.sv
// shared widths, tap counts, pipeline latencies and the kernel mode for the summing back end
package adder_tree_pkg;

    // word width of a feature, a partial sum and the bias
    localparam int FEATURE_WIDTH = 16;

    // channel tag carried beside the data
    localparam int CHANNEL_NO_WIDTH = 5;

    // one 5x5 window, or two 3x3 kernels plus seven unused taps
    localparam int KERNEL_TAPS = 25;
    localparam int KN3_TAPS = 9;

    // clock cycles per stage
    localparam int TREE_LATENCY = 4;
    localparam int SUMMER_LATENCY = 2;
    localparam int TOTAL_LATENCY = TREE_LATENCY + SUMMER_LATENCY;

    // unsigned, wraps modulo 2**FEATURE_WIDTH
    typedef logic [FEATURE_WIDTH-1:0] feature_t;

    // 5x5 gives one sum per window, 3x3 gives an even and an odd sum
    typedef enum logic {
        KN_MODE_5X5 = 1'b0,
        KN_MODE_3X3 = 1'b1
    } kn_mode_e;

endpackage

// File: design/channel_bias_summer.sv
// adds the per-window even and odd sums of one item, then adds the bias, in two stages
`timescale 1ns/1ps

module channel_bias_summer
    import adder_tree_pkg::*;
#(
    parameter int TN = 4
) (
    input  logic              clk,
    input  logic              rst,
    input  feature_t [TN-1:0] i_sums_even,
    input  feature_t [TN-1:0] i_sums_odd,
    input  feature_t          i_bias,
    output feature_t          o_sum_even,
    output feature_t          o_sum_odd
);

    feature_t acc_even;
    feature_t acc_odd;
    feature_t stage1_even;
    feature_t stage1_odd;
    feature_t stage2_even;
    feature_t stage2_odd;

    // window reduction, wraps like the tree
    always_comb begin
        acc_even = '0;
        acc_odd  = '0;
        for (int w = 0; w < TN; w++) begin
            acc_even = acc_even + i_sums_even[w];
            acc_odd  = acc_odd + i_sums_odd[w];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            stage1_even <= '0;
            stage1_odd  <= '0;
        end else begin
            stage1_even <= acc_even;
            stage1_odd  <= acc_odd;
        end
    end

    // bias goes on both results, in 5x5 mode odd is bias only
    always_ff @(posedge clk) begin
        if (rst) begin
            stage2_even <= '0;
            stage2_odd  <= '0;
        end else begin
            stage2_even <= stage1_even + i_bias;
            stage2_odd  <= stage1_odd + i_bias;
        end
    end

    assign o_sum_even = stage2_even;
    assign o_sum_odd  = stage2_odd;

endmodule

// File: design/conv_cfg_regs.sv
// kernel mode and bias registers, loaded by a write strobe while the pipeline is empty
`timescale 1ns/1ps

module conv_cfg_regs
    import adder_tree_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     i_cfg_write,
    input  kn_mode_e i_cfg_mode,
    input  feature_t i_cfg_bias,
    output kn_mode_e o_mode,
    output feature_t o_bias
);

    kn_mode_e mode_q;
    feature_t bias_q;

    // both fields load together, new values seen the cycle after the strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            mode_q <= KN_MODE_5X5;
            bias_q <= '0;
        end else if (i_cfg_write) begin
            mode_q <= i_cfg_mode;
            bias_q <= i_cfg_bias;
        end
    end

    assign o_mode = mode_q;
    assign o_bias = bias_q;

endmodule

// File: design/conv_sum_top.sv
// top of the convolution summing back end: config, TN kernel trees, summer, strobe delay
`timescale 1ns/1ps

module conv_sum_top
    import adder_tree_pkg::*;
#(
    parameter int TN = 4
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          i_cfg_write,
    input  kn_mode_e                      i_cfg_mode,
    input  feature_t                      i_cfg_bias,
    input  logic                          i_enable,
    input  logic [CHANNEL_NO_WIDTH-1:0]   i_channel_no,
    input  feature_t [TN*KERNEL_TAPS-1:0] i_features,
    output logic                          o_valid,
    output logic [CHANNEL_NO_WIDTH-1:0]   o_channel_no,
    output feature_t                      o_sum_even,
    output feature_t                      o_sum_odd
);

    kn_mode_e          cfg_mode;
    feature_t          cfg_bias;
    feature_t [TN-1:0] win_sum_even;
    feature_t [TN-1:0] win_sum_odd;

    conv_cfg_regs u_cfg (
        .clk         (clk),
        .rst         (rst),
        .i_cfg_write (i_cfg_write),
        .i_cfg_mode  (i_cfg_mode),
        .i_cfg_bias  (i_cfg_bias),
        .o_mode      (cfg_mode),
        .o_bias      (cfg_bias)
    );

    // one tree per window, window w owns taps w*25 .. w*25+24
    for (genvar w = 0; w < TN; w++) begin : g_tree
        kernel_adder_tree u_tree (
            .clk        (clk),
            .rst        (rst),
            .i_mode     (cfg_mode),
            .i_taps     (i_features[w*KERNEL_TAPS +: KERNEL_TAPS]),
            .o_sum_even (win_sum_even[w]),
            .o_sum_odd  (win_sum_odd[w])
        );
    end

    channel_bias_summer #(
        .TN (TN)
    ) u_summer (
        .clk         (clk),
        .rst         (rst),
        .i_sums_even (win_sum_even),
        .i_sums_odd  (win_sum_odd),
        .i_bias      (cfg_bias),
        .o_sum_even  (o_sum_even),
        .o_sum_odd   (o_sum_odd)
    );

    valid_delay_line #(
        .DEPTH (TOTAL_LATENCY)
    ) u_delay (
        .clk          (clk),
        .rst          (rst),
        .i_enable     (i_enable),
        .i_channel_no (i_channel_no),
        .o_valid      (o_valid),
        .o_channel_no (o_channel_no)
    );

endmodule

// File: design/kernel_tree/kernel_adder_tree.sv
// four-stage registered adder tree for one 25-tap window, giving 5x5 and 3x3 kernel sums
`timescale 1ns/1ps

module kernel_adder_tree
    import adder_tree_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,
    input  kn_mode_e                   i_mode,
    input  feature_t [KERNEL_TAPS-1:0] i_taps,
    output feature_t                   o_sum_even,
    output feature_t                   o_sum_odd
);

    // tap 2*KN3_TAPS onwards only counts in 5x5 mode
    localparam int REST_BASE = 2 * KN3_TAPS;

    // layer 0, per 3x3 kernel two four-tap sums and the ninth tap
    feature_t [1:0][2:0] l0_kn;
    // taps 18..21 and 22..24
    feature_t [1:0]      l0_rest;

    // layer 1, one value per group
    feature_t [1:0]      l1_kn;
    feature_t            l1_rest;

    // layer 2, 5x5 total plus both 3x3 sums carried along
    feature_t            l2_total;
    feature_t [1:0]      l2_kn;

    // layer 3, output registers
    feature_t            l3_total;
    feature_t [1:0]      l3_kn;

    // layer 0
    always_ff @(posedge clk) begin
        if (rst) begin
            l0_kn   <= '0;
            l0_rest <= '0;
        end else begin
            for (int k = 0; k < 2; k++) begin
                l0_kn[k][0] <= i_taps[k*KN3_TAPS + 0] + i_taps[k*KN3_TAPS + 1]
                             + i_taps[k*KN3_TAPS + 2] + i_taps[k*KN3_TAPS + 3];
                l0_kn[k][1] <= i_taps[k*KN3_TAPS + 4] + i_taps[k*KN3_TAPS + 5]
                             + i_taps[k*KN3_TAPS + 6] + i_taps[k*KN3_TAPS + 7];
                // ninth tap just registered through
                l0_kn[k][2] <= i_taps[k*KN3_TAPS + 8];
            end
            l0_rest[0] <= i_taps[REST_BASE + 0] + i_taps[REST_BASE + 1]
                        + i_taps[REST_BASE + 2] + i_taps[REST_BASE + 3];
            l0_rest[1] <= i_taps[REST_BASE + 4] + i_taps[REST_BASE + 5]
                        + i_taps[REST_BASE + 6];
        end
    end

    // layer 1
    always_ff @(posedge clk) begin
        if (rst) begin
            l1_kn   <= '0;
            l1_rest <= '0;
        end else begin
            for (int k = 0; k < 2; k++) begin
                l1_kn[k] <= l0_kn[k][0] + l0_kn[k][1] + l0_kn[k][2];
            end
            l1_rest <= l0_rest[0] + l0_rest[1];
        end
    end

    // layer 2
    always_ff @(posedge clk) begin
        if (rst) begin
            l2_total <= '0;
            l2_kn    <= '0;
        end else begin
            l2_total <= l1_kn[0] + l1_kn[1] + l1_rest;
            l2_kn    <= l1_kn;
        end
    end

    // layer 3
    always_ff @(posedge clk) begin
        if (rst) begin
            l3_total <= '0;
            l3_kn    <= '0;
        end else begin
            l3_total <= l2_total;
            l3_kn    <= l2_kn;
        end
    end

    // mode is static while items are in flight, so select after the last register
    assign o_sum_even = (i_mode == KN_MODE_3X3) ? l3_kn[0] : l3_total;
    assign o_sum_odd  = (i_mode == KN_MODE_3X3) ? l3_kn[1] : '0;

endmodule

// File: design/valid_delay_line.sv
// shift register that carries the item strobe and channel number beside the datapath
`timescale 1ns/1ps

module valid_delay_line
    import adder_tree_pkg::*;
#(
    parameter int DEPTH = 6
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        i_enable,
    input  logic [CHANNEL_NO_WIDTH-1:0] i_channel_no,
    output logic                        o_valid,
    output logic [CHANNEL_NO_WIDTH-1:0] o_channel_no
);

    // stage 0 is loaded from the inputs, stage DEPTH-1 drives the outputs
    logic [DEPTH-1:0]                        valid_sr;
    logic [DEPTH-1:0][CHANNEL_NO_WIDTH-1:0] chan_sr;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_sr <= '0;
            chan_sr  <= '0;
        end else begin
            valid_sr[0] <= i_enable;
            chan_sr[0]  <= i_channel_no;
            for (int s = 1; s < DEPTH; s++) begin
                valid_sr[s] <= valid_sr[s-1];
                chan_sr[s]  <= chan_sr[s-1];
            end
        end
    end

    assign o_valid      = valid_sr[DEPTH-1];
    assign o_channel_no = chan_sr[DEPTH-1];

endmodule

// File: sim.f
common/adder_tree_pkg.sv
design/conv_cfg_regs.sv
design/kernel_tree/kernel_adder_tree.sv
design/channel_bias_summer.sv
design/valid_delay_line.sv
design/conv_sum_top.sv
verification/conv_sum_checker.sv
verification/conv_sum_monitor.sv
verification/conv_sum_tb.sv

// File: verification/conv_sum_checker.sv
// concurrent assertions bound into conv_sum_top for strobe delay, channel tag and known sums
`timescale 1ns/1ps

module conv_sum_checker
    import adder_tree_pkg::*;
(
    input logic                        clk,
    input logic                        rst,
    input logic                        i_enable,
    input logic [CHANNEL_NO_WIDTH-1:0] i_channel_no,
    input logic                        i_valid,
    input logic [CHANNEL_NO_WIDTH-1:0] i_out_channel_no,
    input feature_t                    i_sum_even,
    input feature_t                    i_sum_odd
);

    // number of failed assertions so far
    int failures = 0;

    // strobe comes out exactly TOTAL_LATENCY edges after it went in
    valid_latency: assert property (@(posedge clk) disable iff (rst)
        i_valid == $past(i_enable, TOTAL_LATENCY))
    else begin
        $error("o_valid does not follow i_enable by %0d cycles", TOTAL_LATENCY);
        failures++;
    end

    channel_latency: assert property (@(posedge clk) disable iff (rst)
        i_valid |-> i_out_channel_no == $past(i_channel_no, TOTAL_LATENCY))
    else begin
        $error("o_channel_no is not the channel sampled %0d cycles earlier", TOTAL_LATENCY);
        failures++;
    end

    // results must be fully driven whenever they are marked valid
    sums_known: assert property (@(posedge clk) disable iff (rst)
        i_valid |-> !$isunknown({i_sum_even, i_sum_odd}))
    else begin
        $error("o_sum_even or o_sum_odd has unknown bits while o_valid is high");
        failures++;
    end

endmodule

// File: verification/conv_sum_monitor.sv
// watches the DUT outputs and compares each valid result with the queue of expected items
`timescale 1ns/1ps

module conv_sum_monitor
    import adder_tree_pkg::*;
(
    input logic                        clk,
    input logic                        rst,
    input logic                        i_cfg_write,
    input logic                        i_valid,
    input logic [CHANNEL_NO_WIDTH-1:0] i_channel_no,
    input feature_t                    i_sum_even,
    input feature_t                    i_sum_odd
);

    logic [CHANNEL_NO_WIDTH-1:0] exp_chan_q[$];
    feature_t                    exp_even_q[$];
    feature_t                    exp_odd_q[$];

    int error_count = 0;
    int check_count = 0;
    int test_errors = 0;
    int test_checks = 0;
    // outputs must stay at their reset values until the first config write
    bit cfg_seen = 1'b0;

    task automatic expect_item(input logic [CHANNEL_NO_WIDTH-1:0] chan,
                               input feature_t sum_even, input feature_t sum_odd);
        exp_chan_q.push_back(chan);
        exp_even_q.push_back(sum_even);
        exp_odd_q.push_back(sum_odd);
    endtask

    function automatic int pending_count();
        return exp_chan_q.size();
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        test_checks++;
        check_count++;
        if (got !== exp) begin
            $display("[ERROR] %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
            test_errors++;
            error_count++;
        end
    endtask

    task automatic finish_test(input int num, input string label);
        $display("test %0d %s: %0d checks, %0d errors", num, label, test_checks, test_errors);
        test_checks = 0;
        test_errors = 0;
    endtask

    // sample on the falling edge, well away from the register updates
    always @(negedge clk) begin : sample
        logic [CHANNEL_NO_WIDTH-1:0] exp_chan;
        feature_t                    exp_even;
        feature_t                    exp_odd;
        if (!rst) begin
            if (i_valid === 1'b1) begin
                if (exp_chan_q.size() == 0) begin
                    $display("o_valid went high at %0t with no item waiting to match it",
                             $time);
                    test_errors++;
                    error_count++;
                end else begin
                    exp_chan = exp_chan_q.pop_front();
                    exp_even = exp_even_q.pop_front();
                    exp_odd  = exp_odd_q.pop_front();
                    check_value("o_channel_no", 32'(i_channel_no), 32'(exp_chan));
                    check_value("o_sum_even", 32'(i_sum_even), 32'(exp_even));
                    check_value("o_sum_odd", 32'(i_sum_odd), 32'(exp_odd));
                end
            end else if (!cfg_seen) begin
                check_value("o_valid", 32'(i_valid), 32'h0);
                check_value("o_channel_no", 32'(i_channel_no), 32'h0);
                check_value("o_sum_even", 32'(i_sum_even), 32'h0);
                check_value("o_sum_odd", 32'(i_sum_odd), 32'h0);
            end
        end
        if (i_cfg_write === 1'b1) begin
            cfg_seen = 1'b1;
        end
    end

endmodule

// File: verification/conv_sum_tb.sv
// testbench top for conv_sum_top, reads the test table and feeds expected results to the monitor
`timescale 1ns/1ps

module conv_sum_tb
    import adder_tree_pkg::*;
();

    localparam int TN = 4;
    localparam int DRAIN_TIMEOUT = 50;
    localparam string DATA_FILE = "verification/conv_sum_testdata.txt";

    logic                          clk = 1'b0;
    logic                          rst;
    logic                          i_cfg_write;
    kn_mode_e                      i_cfg_mode;
    feature_t                      i_cfg_bias;
    logic                          i_enable;
    logic [CHANNEL_NO_WIDTH-1:0]   i_channel_no;
    feature_t [TN*KERNEL_TAPS-1:0] i_features;
    logic                          o_valid;
    logic [CHANNEL_NO_WIDTH-1:0]   o_channel_no;
    feature_t                      o_sum_even;
    feature_t                      o_sum_odd;

    logic [31:0] rng_state;
    bit          run_failed;

    always #5 clk = ~clk;

    conv_sum_top #(
        .TN (TN)
    ) conv_sum_top_i (
        .clk          (clk),
        .rst          (rst),
        .i_cfg_write  (i_cfg_write),
        .i_cfg_mode   (i_cfg_mode),
        .i_cfg_bias   (i_cfg_bias),
        .i_enable     (i_enable),
        .i_channel_no (i_channel_no),
        .i_features   (i_features),
        .o_valid      (o_valid),
        .o_channel_no (o_channel_no),
        .o_sum_even   (o_sum_even),
        .o_sum_odd    (o_sum_odd)
    );

    conv_sum_monitor monitor_i (
        .clk          (clk),
        .rst          (rst),
        .i_cfg_write  (i_cfg_write),
        .i_valid      (o_valid),
        .i_channel_no (o_channel_no),
        .i_sum_even   (o_sum_even),
        .i_sum_odd    (o_sum_odd)
    );

    bind conv_sum_top conv_sum_checker sum_checker_i (
        .clk              (clk),
        .rst              (rst),
        .i_enable         (i_enable),
        .i_channel_no     (i_channel_no),
        .i_valid          (o_valid),
        .i_out_channel_no (o_channel_no),
        .i_sum_even       (o_sum_even),
        .i_sum_odd        (o_sum_odd)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // reference sums, wrapping modulo 2**FEATURE_WIDTH through feature_t
    function automatic void model_sums(input kn_mode_e mode, input feature_t bias,
                                       input feature_t [TN*KERNEL_TAPS-1:0] taps,
                                       output feature_t sum_even, output feature_t sum_odd);
        int t;
        sum_even = bias;
        sum_odd  = bias;
        for (int n = 0; n < TN*KERNEL_TAPS; n++) begin
            t = n % KERNEL_TAPS;
            if (mode == KN_MODE_5X5 || t < KN3_TAPS) begin
                sum_even = sum_even + taps[n];
            end else if (t < 2*KN3_TAPS) begin
                sum_odd = sum_odd + taps[n];
            end
        end
    endfunction

    // kind 0 constant, 1 constant with large junk in taps 18..24, 2 random, 3 random near max
    task automatic fill_item(input int kind, input feature_t value);
        int t;
        for (int n = 0; n < TN*KERNEL_TAPS; n++) begin
            t = n % KERNEL_TAPS;
            case (kind)
                0: i_features[n] = value;
                1: i_features[n] = (t < 2*KN3_TAPS) ? value : '1;
                2: begin
                    rng_state = xorshift32(rng_state);
                    i_features[n] = rng_state[FEATURE_WIDTH-1:0];
                end
                default: begin
                    rng_state = xorshift32(rng_state);
                    i_features[n] = rng_state[FEATURE_WIDTH-1:0] | 16'hf000;
                end
            endcase
        end
    endtask

    task automatic wait_drained(output bit drained);
        int cycles;
        cycles = 0;
        while (monitor_i.pending_count() != 0 && cycles < DRAIN_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        drained = (monitor_i.pending_count() == 0);
    endtask

    task automatic run_test(input int num, input logic [31:0] mode_v, input logic [31:0] bias_v,
                            input logic [31:0] count_v, input logic [31:0] kind_v,
                            input logic [31:0] value_v, input logic [31:0] even_v,
                            input logic [31:0] odd_v, output bit drained);
        kn_mode_e mode;
        feature_t bias;
        feature_t exp_even;
        feature_t exp_odd;
        int       chan;
        mode = kn_mode_e'(mode_v[0]);
        bias = bias_v[FEATURE_WIDTH-1:0];
        @(posedge clk);
        #1;
        i_cfg_write = 1'b1;
        i_cfg_mode  = mode;
        i_cfg_bias  = bias;
        @(posedge clk);
        #1;
        i_cfg_write = 1'b0;
        @(posedge clk);
        #1;
        // one item per cycle, back to back
        for (int i = 0; i < int'(count_v); i++) begin
            fill_item(int'(kind_v), value_v[FEATURE_WIDTH-1:0]);
            if (kind_v < 2) begin
                exp_even = even_v[FEATURE_WIDTH-1:0];
                exp_odd  = odd_v[FEATURE_WIDTH-1:0];
                chan     = num + i;
            end else begin
                model_sums(mode, bias, i_features, exp_even, exp_odd);
                rng_state = xorshift32(rng_state);
                chan      = int'(rng_state);
            end
            i_channel_no = chan[CHANNEL_NO_WIDTH-1:0];
            i_enable     = 1'b1;
            monitor_i.expect_item(i_channel_no, exp_even, exp_odd);
            @(posedge clk);
            #1;
        end
        i_enable     = 1'b0;
        i_channel_no = '0;
        i_features   = '0;
        wait_drained(drained);
        monitor_i.finish_test(num, $sformatf("%s kind %0d", mode.name(), kind_v));
    endtask

    initial begin : main
        int               fd;
        int               fields;
        int               tests_run;
        bit               drained;
        logic [8*160-1:0] line;
        logic [31:0]      f_mode, f_bias, f_count, f_kind, f_value, f_even, f_odd;
        rst          = 1'b1;
        i_cfg_write  = 1'b0;
        i_cfg_mode   = KN_MODE_5X5;
        i_cfg_bias   = '0;
        i_enable     = 1'b0;
        // junk on the data inputs, the reset must keep it out of the pipeline
        i_channel_no = '1;
        i_features   = '1;
        rng_state    = 32'he1a66ef2;
        run_failed   = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rst          = 1'b0;
        i_channel_no = '0;
        i_features   = '0;
        // idle cycles so the monitor sees the reset state
        repeat (4) @(posedge clk);
        monitor_i.finish_test(0, "reset state");
        tests_run = 1;
        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            $display("could not open the test data file %s", DATA_FILE);
            run_failed = 1'b1;
        end else begin
            while (!run_failed && $fgets(line, fd) != 0) begin
                fields = $sscanf(line, "%h %h %h %h %h %h %h", f_mode, f_bias, f_count,
                                 f_kind, f_value, f_even, f_odd);
                if (fields == 7) begin
                    run_test(tests_run, f_mode, f_bias, f_count, f_kind, f_value,
                             f_even, f_odd, drained);
                    if (!drained) begin
                        $display("timeout: test %0d still had items in flight after %0d cycles",
                                 tests_run, DRAIN_TIMEOUT);
                        run_failed = 1'b1;
                    end
                    tests_run++;
                end
            end
            $fclose(fd);
        end
        $display("summary: %0d tests, %0d checks, %0d value errors, %0d assertion failures",
                 tests_run, monitor_i.check_count, monitor_i.error_count,
                 conv_sum_top_i.sum_checker_i.failures);
        if (run_failed || monitor_i.error_count != 0 ||
            conv_sum_top_i.sum_checker_i.failures != 0) begin
            $display("FAIL: see errors above");
        end else begin
            $display("PASS: all tests");
        end
        $finish;
    end

endmodule

// File: verification/conv_sum_testdata.txt
# columns in hex: mode bias count kind value exp_even exp_odd (mode 0 is 5x5, mode 1 is 3x3)
# kind 0 constant, 1 constant with taps 18..24 at ffff, 2 random, 3 random near max
# expected sums assume TN = 4 and are ignored for kinds 2 and 3
0 0000 4 0 0001 0064 0000
0 0010 3 0 0007 02cc 0010
1 0005 4 1 0003 0071 0071
1 0100 2 1 0123 29ec 29ec
0 1234 10 2 0000 0000 0000
1 00ff 10 2 0000 0000 0000
0 ffff 4 0 ffff ff9b ffff
1 8000 4 1 ffff 7fdc 7fdc
0 0000 c 3 0000 0000 0000
1 7fff c 3 0000 0000 0000
0 0001 8 2 0000 0000 0000
1 0000 5 0 0002 0048 0048
